// ==== bench/id_stage_checker.sv ====
module id_stage_checker (
    input logic            clk,
    input logic            rst,
    input id_pkg::id_ex_t  id_ex_i,
    input id_pkg::branch_t br_i,
    input logic            load_stall_i
);
    import id_pkg::*;

    // only lw asks for a load stall
    load_stall_is_load: assert property (@(posedge clk) disable iff (rst)
        load_stall_i |-> (id_ex_i.inst[31:26] == 6'b100011 &&
                          id_ex_i.mem_en && !id_ex_i.mem_we))
        else $error("load stall raised without a load decode");

    // invalid held entry shows up as the bubble word
    no_taken_on_bubble: assert property (@(posedge clk) disable iff (rst)
        (id_ex_i.inst == INST_NOP) |-> !br_i.taken)
        else $error("branch taken on an invalid held entry");

    no_write_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !id_ex_i.rf_we)
        else $error("rf_we set during reset");

endmodule

bind id_stage id_stage_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .id_ex_i      (id_ex_o),
    .br_i         (br_o),
    .load_stall_i (load_stall_o)
);

// ==== bench/id_stage_tb.sv ====
module id_stage_tb;
    import id_pkg::*;

    localparam int NCOL    = 17;
    localparam int MAX_VEC = 40;
    localparam int LIMIT   = 20;

    logic        clk;
    logic        rst;
    stall_t      stall_i;
    fetch_t      fetch_i;
    logic [31:0] inst_rdata_i;
    rf_write_t   ex_fwd_i;
    rf_write_t   mem_fwd_i;
    rf_write_t   wb_fwd_i;
    id_ex_t      id_ex_o;
    branch_t     br_o;
    logic        load_stall_o;

    // columns per line, see the header of the vector file
    logic [31:0] vec [MAX_VEC*NCOL];
    int          errors;
    int          tests;
    int          failed_tests;
    int          test_errors;

    id_stage dut_i (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .id_ex_o      (id_ex_o),
        .br_o         (br_o),
        .load_stall_o (load_stall_o)
    );

    always #4 clk = ~clk;

    task automatic wait_fall();
        int n;
        n = 0;
        while (clk !== 1'b1 && n < LIMIT) begin
            #1;
            n++;
        end
        while (clk !== 1'b0 && n < LIMIT) begin
            #1;
            n++;
        end
        if (n >= LIMIT) begin
            $display("timed out waiting for a falling clock edge at %0t", $time);
            $display("test failed");
            $finish;
        end
    endtask

    function automatic rf_write_t to_fwd(input logic [31:0] a, input logic [31:0] d);
        return '{we: a[5], waddr: a[4:0], wdata: d};
    endfunction

    task automatic clear_inputs();
        stall_i   = '0;
        fetch_i   = '0;
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
        wb_fwd_i  = '0;
    endtask

    // pc is captured at the rising edge after this
    task automatic capture_pc(input logic [31:0] pc);
        wait_fall();
        clear_inputs();
        fetch_i = '{valid: 1'b1, pc: pc};
    endtask

    // memory word for the captured pc arrives one cycle later
    task automatic present_inst(input int base);
        wait_fall();
        fetch_i      = '0;
        inst_rdata_i = vec[base+2];
        stall_i      = stall_t'(vec[base+3][1:0]);
        ex_fwd_i     = to_fwd(vec[base+4], vec[base+5]);
        mem_fwd_i    = to_fwd(vec[base+6], vec[base+7]);
        wb_fwd_i     = to_fwd(vec[base+8], vec[base+9]);
    endtask

    task automatic check_word(input int idx, input string what,
                              input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: vector %0d %s got %h expected %h",
                     $time, idx, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int idx, input int base,
                                 input logic [31:0] exp_pc, input logic [31:0] exp_inst);
        check_word(idx, "pc", id_ex_o.pc, exp_pc);
        check_word(idx, "inst", id_ex_o.inst, exp_inst);
        check_word(idx, "rs_value", id_ex_o.rs_value, vec[base+10]);
        check_word(idx, "rt_value", id_ex_o.rt_value, vec[base+11]);
        check_word(idx, "alu_op", {28'd0, id_ex_o.alu_op}, vec[base+12]);
        check_word(idx, "operand selects", {28'd0, id_ex_o.src1_sel, id_ex_o.src2_sel},
                   vec[base+13]);
        check_word(idx, "flags", {27'd0, id_ex_o.rf_we, id_ex_o.mem_en, id_ex_o.mem_we,
                                  load_stall_o, br_o.taken}, vec[base+14]);
        check_word(idx, "load_result", {31'd0, id_ex_o.load_result},
                   {31'd0, vec[base+14][1]});
        check_word(idx, "rf_waddr", {27'd0, id_ex_o.rf_waddr}, vec[base+15]);
        check_word(idx, "target", br_o.target, vec[base+16]);
    endtask

    task automatic finish_test(input int idx, input string name);
        tests++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("vector %0d %s: ok", idx, name);
        end else begin
            failed_tests++;
            $display("vector %0d %s: %0d errors", idx, name, test_errors);
        end
    endtask

    initial begin
        int          base;
        logic [31:0] kind;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_rdata_i = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        clear_inputs();
        $readmemh("bench/id_stage_vectors.txt", vec);

        repeat (8) wait_fall();
        rst = 1'b0;
        // still before the first rising edge out of reset
        #2;
        test_errors = 0;
        if ({id_ex_o.rf_we, id_ex_o.mem_en, id_ex_o.mem_we,
             br_o.taken, load_stall_o} !== 5'b00000) begin
            $display("Fail at %0t: control outputs are not idle after reset", $time);
            test_errors++;
        end
        finish_test(-1, "reset");

        for (int v = 0; v < MAX_VEC; v++) begin
            base        = v * NCOL;
            kind        = vec[base];
            test_errors = 0;
            if ($isunknown(kind) || kind == 32'hf) begin
                break;
            end
            case (kind)
                32'd0: begin
                    wait_fall();
                    clear_inputs();
                    wb_fwd_i = to_fwd(vec[base+8], vec[base+9]);
                    finish_test(v, "write");
                end
                32'd1: begin
                    capture_pc(vec[base+1]);
                    present_inst(base);
                    #2;
                    check_outputs(v, base, vec[base+1], vec[base+2]);
                    finish_test(v, "decode");
                end
                32'd2: begin
                    capture_pc(vec[base+1]);
                    present_inst(base);
                    // fetch offers the next pc, which the bubble must drop
                    fetch_i = '{valid: 1'b1, pc: vec[base+1] + 32'd4};
                    wait_fall();
                    clear_inputs();
                    #2;
                    check_outputs(v, base, 32'd0, INST_NOP);
                    finish_test(v, "stall bubble");
                end
                32'd3: begin
                    capture_pc(vec[base+1]);
                    present_inst(base);
                    #2;
                    check_outputs(v, base, vec[base+1], vec[base+2]);
                    // memory output moves while both stops are held
                    for (int c = 0; c < 3; c++) begin
                        wait_fall();
                        inst_rdata_i = ~vec[base+2] ^ 32'(c);
                        #2;
                        check_outputs(v, base, vec[base+1], vec[base+2]);
                    end
                    wait_fall();
                    clear_inputs();
                    finish_test(v, "stall hold");
                end
                default: begin
                    $display("vector %0d has an unknown operation kind %h", v, kind);
                    test_errors++;
                    finish_test(v, "unknown");
                end
            endcase
        end

        $display("%0d tests, %0d failed, %0d failed checks", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== bench/id_stage_vectors.txt ====
// kind pc inst stall exa exd mema memd wba wbd  (fwd addr word: bit5 we, bits4:0 reg)
// exp: rs rt alu sel{src1,src2} flags{rf_we,mem_en,mem_we,ld,taken} waddr target
// kind 0 write, 1 decode, 2 stall bubble, 3 stall hold, f end
0 0 0 0 0 0 0 0 21 5 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 22 fffffff0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 23 5 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 28 1000 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 29 9 0 0 0 0 0 0 0
1 00400000 00222021 0 0 0 0 0 0 0 5 fffffff0 0 0 10 4 0
1 00400004 00602823 0 0 0 0 0 0 0 5 0 1 0 10 5 0
1 00400008 0041302b 0 0 0 0 0 0 0 fffffff0 5 3 0 10 6 0
1 0040000c 00023903 0 0 0 0 0 0 0 0 fffffff0 9 8 10 7 0
1 00400010 242afffc 0 0 0 0 0 0 0 5 0 0 1 10 a 0
1 00400014 352b8000 0 0 0 0 0 0 0 9 0 5 3 10 b 0
1 00400018 3c0c1234 0 0 0 0 0 0 0 0 0 a 1 10 c 0
1 0040001c 8d0d0008 0 0 0 0 0 0 0 1000 0 0 1 1a d 0
1 00400020 ad010004 0 0 0 0 0 0 0 1000 5 0 1 c 0 0
1 00400100 10230004 0 0 0 0 0 0 0 5 5 0 0 1 0 00400114
1 00400100 14230004 0 0 0 0 0 0 0 5 5 0 0 0 0 0
1 00400100 0441fffe 0 0 0 0 0 0 0 fffffff0 5 0 0 0 0 0
1 00400100 0440fffe 0 0 0 0 0 0 0 fffffff0 0 0 0 1 0 004000fc
1 00400100 08100040 0 0 0 0 0 0 0 0 0 0 0 1 0 00400100
1 00400100 0c100040 0 0 0 0 0 0 0 0 0 0 6 11 1f 00400100
1 00400100 01000008 0 0 0 0 0 0 0 1000 0 0 0 1 0 00001000
1 00400200 00222021 0 21 aaaa 21 bbbb 22 cccc aaaa cccc 0 0 10 4 0
1 00400204 00222021 0 3f 1234 22 dddd 22 eeee 5 dddd 0 0 10 4 0
1 00400208 00222021 0 0 0 0 0 21 7777 7777 eeee 0 0 10 4 0
2 00400300 00222021 1 0 0 0 0 0 0 0 0 b 0 0 0 0
3 00400304 8d0d0008 3 0 0 0 0 0 0 1000 0 0 1 1a d 0
f

// ==== hdl/branch_unit.sv ====
module branch_unit (
    input  logic              [31:0] pc_i,
    input  logic              [31:0] inst_i,
    input  logic              [31:0] rs_value_i,
    input  logic              [31:0] rt_value_i,
    input  id_pkg::br_kind_e         br_kind_i,
    output id_pkg::branch_t          br_o
);
    import id_pkg::*;

    logic [31:0] pc_plus4;
    logic [31:0] offset_target;
    logic [31:0] jump_target;
    logic        taken;
    logic [31:0] target;

    assign pc_plus4      = pc_i + 32'd4;
    assign offset_target = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], inst_i[25:0], 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = offset_target;
        case (br_kind_i)
            BR_BEQ:  taken = (rs_value_i == rt_value_i);
            BR_BNE:  taken = (rs_value_i != rt_value_i);
            BR_BGEZ: taken = !rs_value_i[31];
            BR_BLTZ: taken = rs_value_i[31];
            BR_J, BR_JAL: begin
                taken  = 1'b1;
                target = jump_target;
            end
            BR_JR: begin
                taken  = 1'b1;
                target = rs_value_i;
            end
            default: ;
        endcase
    end

    assign br_o.taken  = taken;
    assign br_o.target = taken ? target : 32'd0;

endmodule

// ==== hdl/fetch_latch.sv ====
module fetch_latch (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::stall_t stall_i,
    input  id_pkg::fetch_t fetch_i,
    input  logic [31:0]    inst_rdata_i,
    output logic [31:0]    pc_o,
    output logic [31:0]    inst_o
);
    import id_pkg::*;

    fetch_t      held;
    logic        buf_valid;
    logic [31:0] buf_inst;
    logic        buf_load;

    // first cycle of a full stall grabs the memory word
    assign buf_load = stall_i.fetch_stop && stall_i.decode_stop && !buf_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            held      <= '0;
            buf_valid <= 1'b0;
        end else if (stall_i.fetch_stop && !stall_i.decode_stop) begin
            held      <= '0;
            buf_valid <= 1'b0;
        end else if (!stall_i.fetch_stop) begin
            held      <= fetch_i;
            buf_valid <= 1'b0;
        end else if (buf_load) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_inst <= inst_rdata_i;
        end
    end

    assign pc_o   = held.pc;
    assign inst_o = !held.valid ? INST_NOP :
                    buf_valid   ? buf_inst : inst_rdata_i;

endmodule

// ==== hdl/id_pkg.sv ====
package id_pkg;

    // pipeline control levels seen by decode
    typedef struct packed {
        logic decode_stop;
        logic fetch_stop;
    } stall_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_t;

    // one pending register write, also the writeback port
    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_write_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_NONE
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS, SRC1_PC, SRC1_SA
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT, SRC2_SIMM, SRC2_EIGHT, SRC2_ZIMM
    } src2_sel_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BLTZ, BR_J, BR_JAL, BR_JR
    } br_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        src1_sel_e   src1_sel;
        src2_sel_e   src2_sel;
        logic        mem_en;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic        load_result;
        br_kind_e    br_kind;
    } decode_ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        alu_op_e     alu_op;
        src1_sel_e   src1_sel;
        src2_sel_e   src2_sel;
        logic        mem_en;
        logic        mem_we;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic        load_result;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
    } id_ex_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branch_t;

    localparam logic [4:0]  LINK_REG = 5'd31;
    localparam logic [31:0] INST_NOP = 32'h0000_0000;

endpackage

// ==== hdl/id_stage.sv ====
module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::stall_t    stall_i,
    input  id_pkg::fetch_t    fetch_i,
    input  logic [31:0]       inst_rdata_i,
    input  id_pkg::rf_write_t ex_fwd_i,
    input  id_pkg::rf_write_t mem_fwd_i,
    input  id_pkg::rf_write_t wb_fwd_i,
    output id_pkg::id_ex_t    id_ex_o,
    output id_pkg::branch_t   br_o,
    output logic              load_stall_o
);
    import id_pkg::*;

    logic [31:0]  pc;
    logic [31:0]  inst;
    logic [31:0]  rf_rs;
    logic [31:0]  rf_rt;
    logic [31:0]  rs_value;
    logic [31:0]  rt_value;
    decode_ctrl_t ctrl;

    fetch_latch u_fetch_latch (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .pc_o         (pc),
        .inst_o       (inst)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (inst[25:21]),
        .raddr2_i (inst[20:16]),
        .wr_i     (wb_fwd_i),
        .rdata1_o (rf_rs),
        .rdata2_o (rf_rt)
    );

    operand_bypass u_operand_bypass (
        .rs_i       (inst[25:21]),
        .rt_i       (inst[20:16]),
        .rf_rs_i    (rf_rs),
        .rf_rt_i    (rf_rt),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .wb_fwd_i   (wb_fwd_i),
        .rs_value_o (rs_value),
        .rt_value_o (rt_value)
    );

    inst_decoder u_inst_decoder (
        .inst_i       (inst),
        .ctrl_o       (ctrl),
        .load_stall_o (load_stall_o)
    );

    branch_unit u_branch_unit (
        .pc_i       (pc),
        .inst_i     (inst),
        .rs_value_i (rs_value),
        .rt_value_i (rt_value),
        .br_kind_i  (ctrl.br_kind),
        .br_o       (br_o)
    );

    // branch kind stays in decode
    assign id_ex_o = '{
        pc:          pc,
        inst:        inst,
        alu_op:      ctrl.alu_op,
        src1_sel:    ctrl.src1_sel,
        src2_sel:    ctrl.src2_sel,
        mem_en:      ctrl.mem_en,
        mem_we:      ctrl.mem_we,
        rf_we:       ctrl.rf_we,
        rf_waddr:    ctrl.rf_waddr,
        load_result: ctrl.load_result,
        rs_value:    rs_value,
        rt_value:    rt_value
    };

endmodule

// ==== hdl/inst_decoder.sv ====
module inst_decoder (
    input  logic                 [31:0] inst_i,
    output id_pkg::decode_ctrl_t        ctrl_o,
    output logic                        load_stall_o
);
    import id_pkg::*;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] funct;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign sa     = inst_i[10:6];
    assign funct  = inst_i[5:0];

    function automatic alu_op_e funct_op(input logic [5:0] fn);
        case (fn)
            FN_ADDU: return ALU_ADD;
            FN_SUBU: return ALU_SUB;
            FN_AND:  return ALU_AND;
            FN_OR:   return ALU_OR;
            FN_XOR:  return ALU_XOR;
            FN_SLT:  return ALU_SLT;
            FN_SLTU: return ALU_SLTU;
            FN_SLL:  return ALU_SLL;
            FN_SRL:  return ALU_SRL;
            FN_SRA:  return ALU_SRA;
            default: return ALU_NONE;
        endcase
    endfunction

    function automatic alu_op_e imm_op(input logic [5:0] op);
        case (op)
            OP_SLTI: return ALU_SLT;
            OP_ANDI: return ALU_AND;
            OP_ORI:  return ALU_OR;
            OP_XORI: return ALU_XOR;
            OP_LUI:  return ALU_LUI;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.alu_op   = ALU_NONE;
        ctrl_o.src1_sel = SRC1_RS;
        ctrl_o.src2_sel = SRC2_RT;
        ctrl_o.br_kind  = BR_NONE;
        // the all-zero word is the bubble, not sll $0
        if (inst_i != INST_NOP) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU: begin
                            if (sa == 5'd0) begin
                                ctrl_o.alu_op   = funct_op(funct);
                                ctrl_o.rf_we    = 1'b1;
                                ctrl_o.rf_waddr = rd;
                            end
                        end
                        FN_SLL, FN_SRL, FN_SRA: begin
                            if (rs == 5'd0) begin
                                ctrl_o.alu_op   = funct_op(funct);
                                ctrl_o.src1_sel = SRC1_SA;
                                ctrl_o.rf_we    = 1'b1;
                                ctrl_o.rf_waddr = rd;
                            end
                        end
                        FN_JR: begin
                            if (rt == 5'd0 && rd == 5'd0 && sa == 5'd0) begin
                                ctrl_o.alu_op  = ALU_ADD;
                                ctrl_o.br_kind = BR_JR;
                            end
                        end
                        default: ;
                    endcase
                end
                OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    ctrl_o.alu_op   = imm_op(opcode);
                    ctrl_o.src2_sel = (opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ?
                                      SRC2_ZIMM : SRC2_SIMM;
                    ctrl_o.rf_we    = 1'b1;
                    ctrl_o.rf_waddr = rt;
                end
                OP_LW: begin
                    ctrl_o.alu_op      = ALU_ADD;
                    ctrl_o.src2_sel    = SRC2_SIMM;
                    ctrl_o.mem_en      = 1'b1;
                    ctrl_o.rf_we       = 1'b1;
                    ctrl_o.rf_waddr    = rt;
                    ctrl_o.load_result = 1'b1;
                end
                OP_SW: begin
                    ctrl_o.alu_op   = ALU_ADD;
                    ctrl_o.src2_sel = SRC2_SIMM;
                    ctrl_o.mem_en   = 1'b1;
                    ctrl_o.mem_we   = 1'b1;
                end
                OP_BEQ, OP_BNE: begin
                    ctrl_o.alu_op  = ALU_ADD;
                    ctrl_o.br_kind = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                end
                OP_REGIMM: begin
                    if (rt == 5'd0 || rt == 5'd1) begin
                        ctrl_o.alu_op  = ALU_ADD;
                        ctrl_o.br_kind = (rt == 5'd1) ? BR_BGEZ : BR_BLTZ;
                    end
                end
                OP_J: begin
                    ctrl_o.alu_op  = ALU_ADD;
                    ctrl_o.br_kind = BR_J;
                end
                OP_JAL: begin
                    // link value is pc + 8
                    ctrl_o.alu_op   = ALU_ADD;
                    ctrl_o.src1_sel = SRC1_PC;
                    ctrl_o.src2_sel = SRC2_EIGHT;
                    ctrl_o.rf_we    = 1'b1;
                    ctrl_o.rf_waddr = LINK_REG;
                    ctrl_o.br_kind  = BR_JAL;
                end
                default: ;
            endcase
        end
    end

    assign load_stall_o = ctrl_o.load_result;

endmodule

// ==== hdl/operand_bypass.sv ====
module operand_bypass (
    input  logic [4:0]        rs_i,
    input  logic [4:0]        rt_i,
    input  logic [31:0]       rf_rs_i,
    input  logic [31:0]       rf_rt_i,
    input  id_pkg::rf_write_t ex_fwd_i,
    input  id_pkg::rf_write_t mem_fwd_i,
    input  id_pkg::rf_write_t wb_fwd_i,
    output logic [31:0]       rs_value_o,
    output logic [31:0]       rt_value_o
);
    import id_pkg::*;

    // newest pending write wins
    function automatic logic [31:0] pick(
        input logic [4:0]  addr,
        input logic [31:0] rf_val,
        input rf_write_t   ex,
        input rf_write_t   mem,
        input rf_write_t   wb
    );
        if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end else if (wb.we && wb.waddr == addr) begin
            return wb.wdata;
        end
        return rf_val;
    endfunction

    assign rs_value_o = pick(rs_i, rf_rs_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
    assign rt_value_o = pick(rt_i, rf_rt_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);

endmodule

// ==== hdl/reg_file.sv ====
module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic [4:0]        raddr1_i,
    input  logic [4:0]        raddr2_i,
    input  id_pkg::rf_write_t wr_i,
    output logic [31:0]       rdata1_o,
    output logic [31:0]       rdata2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != 5'd0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // register 0 is hardwired
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

// ==== id_stage.f ====
hdl/id_pkg.sv
hdl/fetch_latch.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/inst_decoder.sv
hdl/branch_unit.sv
hdl/id_stage.sv
bench/id_stage_checker.sv
bench/id_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/id_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
